//--- logic/rv32i_pkg.sv
// RV32I decode stage shared definitions
// Fixed constants, instruction format views and the decode bundles
// passed between the decode submodules

package rv32i_pkg;

  // ----------------------------------------
  // Widths and fixed values
  // ----------------------------------------
  localparam int XLEN      = 32;
  localparam int REG_IDX_W = 5;

  // Trap entry handed to the ALU on ECALL/EBREAK
  localparam logic [XLEN-1:0] TRAP_VECTOR = 32'h0000_0004;

  // ADDI x0, x0, 0
  localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;

  // Synchronous exception causes, mcause encoding
  localparam logic [3:0] CAUSE_IADDR_ALIGN = 4'd0;
  localparam logic [3:0] CAUSE_ILLEGAL     = 4'd2;
  localparam logic [3:0] CAUSE_BREAKPOINT  = 4'd3;
  localparam logic [3:0] CAUSE_ECALL       = 4'd11;

  // ----------------------------------------
  // Opcode groups, opcode[6:2]
  // ----------------------------------------
  // OP-IMM, bit 3 set gives OP
  localparam logic [4:0] OP_GRP_ALU        = 5'b00100;
  // LOAD, bit 3 set gives STORE
  localparam logic [4:0] OP_GRP_LOAD_STORE = 5'b00000;
  // AUIPC, bit 3 set gives LUI
  localparam logic [4:0] OP_GRP_UPPER      = 5'b00101;
  localparam logic [4:0] OP_GRP_BRANCH     = 5'b11000;
  // JALR, bit 1 set gives JAL
  localparam logic [4:0] OP_GRP_JUMP       = 5'b11001;
  localparam logic [4:0] OP_GRP_FENCE      = 5'b00011;
  localparam logic [4:0] OP_GRP_SYSTEM     = 5'b11100;

  // Compare masks for the groups split on one opcode bit
  localparam logic [4:0] OP_GRP_MASK_B3 = 5'b10111;
  localparam logic [4:0] OP_GRP_MASK_B1 = 5'b11101;

  // ----------------------------------------
  // Instruction format views
  // ----------------------------------------
  typedef struct packed {
    logic [6:0]           funct7;
    logic [REG_IDX_W-1:0] rs2;
    logic [REG_IDX_W-1:0] rs1;
    logic [2:0]           funct3;
    logic [REG_IDX_W-1:0] rd;
    logic [6:0]           opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]          imm_11_0;
    logic [REG_IDX_W-1:0] rs1;
    logic [2:0]           funct3;
    logic [REG_IDX_W-1:0] rd;
    logic [6:0]           opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0]           imm_11_5;
    logic [REG_IDX_W-1:0] rs2;
    logic [REG_IDX_W-1:0] rs1;
    logic [2:0]           funct3;
    logic [4:0]           imm_4_0;
    logic [6:0]           opcode;
  } s_fmt_t;

  typedef struct packed {
    logic                 imm_12;
    logic [5:0]           imm_10_5;
    logic [REG_IDX_W-1:0] rs2;
    logic [REG_IDX_W-1:0] rs1;
    logic [2:0]           funct3;
    logic [3:0]           imm_4_1;
    logic                 imm_11;
    logic [6:0]           opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0]          imm_31_12;
    logic [REG_IDX_W-1:0] rd;
    logic [6:0]           opcode;
  } u_fmt_t;

  typedef struct packed {
    logic                 imm_20;
    logic [9:0]           imm_10_1;
    logic                 imm_11;
    logic [7:0]           imm_19_12;
    logic [REG_IDX_W-1:0] rd;
    logic [6:0]           opcode;
  } j_fmt_t;

  // One instruction word, read in whichever format applies
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } instr_u;

  // ----------------------------------------
  // Decode bundles
  // ----------------------------------------
  // Instruction categories from the opcode
  typedef struct packed {
    logic alu;
    logic alu_imm;
    logic ld_st;
    logic store;
    logic upper;
    logic upper_lui;
    logic branch;
    logic jump;
    logic jal;
    logic fence;
    logic system;
    logic illegal;
    logic no_wb;
  } instr_class_t;

  // Operation strobes to the ALU
  typedef struct packed {
    logic       branch;
    logic       jump;
    logic       system;
    logic       load;
    logic       store;
    // 0 byte, 1 half word, 2 word, bit 2 zero extends loads
    logic [2:0] ld_st_width;
  } op_ctrl_t;

  typedef struct packed {
    logic arith;
    logic add_nsub;
    logic cmp_unsigned;
    logic cmp_is_lt;
    logic cmp_is_ge;
    logic cmp_is_eq;
    logic cmp_is_ne;
    logic bit_is_and;
    logic bit_is_or;
    logic bit_is_xor;
    logic shift_arith;
    logic shift_left;
    logic shift_right;
  } alu_ctrl_t;

  // ALU data and the source index of each input, for ALU side forwarding
  typedef struct packed {
    logic [XLEN-1:0]      a;
    logic [XLEN-1:0]      b;
    logic [XLEN-1:0]      offset;
    logic [REG_IDX_W-1:0] a_rs_idx;
    logic [REG_IDX_W-1:0] b_rs_idx;
  } operands_t;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [3:0]      cause;
  } exc_t;

endpackage

//--- logic/instr_latch.sv
// Phase 2 instruction register
// Also drives the register file read indexes, held while stalled

`timescale 1ns/1ps

module instr_latch
  import rv32i_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic [XLEN-1:0]      instr,
  input  logic                 stall,
  output instr_u               instr_reg,
  output logic [REG_IDX_W-1:0] rs1_prefetch,
  output logic [REG_IDX_W-1:0] rs2_prefetch
);

  instr_u               instr_in;
  logic [REG_IDX_W-1:0] rs1_pf_held;
  logic [REG_IDX_W-1:0] rs2_pf_held;

  assign instr_in = instr;

  // Fetch side indexes go straight to the register file
  // so the read data lines up with instr_reg
  assign rs1_prefetch = stall ? rs1_pf_held : instr_in.r.rs1;
  assign rs2_prefetch = stall ? rs2_pf_held : instr_in.r.rs2;

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      // Start phase 2 on a NOP
      instr_reg   <= NOP_INSTR;
      rs1_pf_held <= '0;
      rs2_pf_held <= '0;
    end
    else if (!stall)
    begin
      instr_reg   <= instr_in;
      rs1_pf_held <= rs1_prefetch;
      rs2_pf_held <= rs2_prefetch;
    end
  end

  // Register file must keep seeing the same indexes while the stage is stalled
  a_prefetch_hold : assert property (
    @(posedge clk) disable iff (!reset_n)
    stall && $past(stall) |-> $stable(rs1_prefetch) && $stable(rs2_prefetch)
  );

endmodule

//--- logic/opcode_classify.sv
// Opcode classifier
// Sorts the phase 2 instruction into categories, flags illegal
// encodings and derives the operation strobes and ALU controls

`timescale 1ns/1ps

module opcode_classify
  import rv32i_pkg::*;
(
  input  instr_u       instr_reg,
  output instr_class_t cls,
  output op_ctrl_t     op_next,
  output alu_ctrl_t    alu_next
);

  logic [6:0] opcode;
  logic [4:0] grp;
  logic [2:0] funct3;
  logic       bit30;
  logic       shift_op;
  logic       bad_enc;
  logic       grp_alu, grp_ld_st, grp_upper, grp_branch;
  logic       grp_jump, grp_fence, grp_system;

  assign opcode = instr_reg.r.opcode;
  assign grp    = opcode[6:2];
  assign funct3 = instr_reg.r.funct3;
  assign bit30  = instr_reg.r.funct7[5];

  // ----------------------------------------
  // Group match
  // ----------------------------------------
  assign grp_alu    = (grp & OP_GRP_MASK_B3) == OP_GRP_ALU;
  assign grp_ld_st  = (grp & OP_GRP_MASK_B3) == OP_GRP_LOAD_STORE;
  assign grp_upper  = (grp & OP_GRP_MASK_B3) == OP_GRP_UPPER;
  assign grp_branch = grp == OP_GRP_BRANCH;
  assign grp_jump   = (grp & OP_GRP_MASK_B1) == OP_GRP_JUMP;
  assign grp_fence  = grp == OP_GRP_FENCE;
  assign grp_system = grp == OP_GRP_SYSTEM;

  // SLL/SRL/SRA in either form, funct3 1 or 5
  assign shift_op = grp_alu && (funct3[1:0] == 2'b01);

  // 16 bit (low bits not 11), 48 bit and wider (low five bits set),
  // or a shift with funct7 bit 25 set
  assign bad_enc = ~&opcode[1:0] | &opcode[4:0] | (shift_op & instr_reg.r.funct7[0]);

  // ----------------------------------------
  // Categories
  // ----------------------------------------
  always_comb
  begin
    cls.alu       = ~bad_enc & grp_alu;
    cls.alu_imm   = cls.alu & ~grp[3];
    cls.ld_st     = ~bad_enc & grp_ld_st;
    cls.store     = cls.ld_st & grp[3];
    cls.upper     = ~bad_enc & grp_upper;
    cls.upper_lui = cls.upper & grp[3];
    cls.branch    = ~bad_enc & grp_branch;
    cls.jump      = ~bad_enc & grp_jump;
    cls.jal       = cls.jump & grp[1];
    cls.fence     = ~bad_enc & grp_fence;
    // ECALL/EBREAK only, bit 21 would mark a return
    cls.system    = ~bad_enc & grp_system & ~|funct3 & ~instr_reg.r.rs2[1];
    cls.illegal   = bad_enc | ~(grp_alu | grp_ld_st | grp_upper | grp_branch |
                                grp_jump | grp_fence | grp_system);
    // Nothing to write back for these, rd goes out as x0
    cls.no_wb     = cls.store | cls.branch | cls.fence | cls.illegal | grp_system;
  end

  // Strobes, width is funct3 straight through
  always_comb
  begin
    op_next.branch      = cls.branch;
    op_next.jump        = cls.jump;
    op_next.system      = cls.system;
    op_next.load        = cls.ld_st & ~cls.store;
    op_next.store       = cls.store;
    op_next.ld_st_width = funct3;
  end

  // ----------------------------------------
  // ALU controls
  // ----------------------------------------
  always_comb
  begin
    // ADD/SUB for funct3 0, also LUI/AUIPC
    alu_next.arith        = (cls.alu & ~|funct3) | cls.upper;
    // Low for SUB only, which needs the register form
    alu_next.add_nsub     = ~(cls.alu & ~cls.alu_imm & bit30);
    // BLTU/BGEU and SLTU/SLTIU
    alu_next.cmp_unsigned = (cls.branch & funct3[1]) | (cls.alu & funct3[0]);
    alu_next.cmp_is_eq    = cls.branch & ~funct3[2] & ~funct3[0];
    alu_next.cmp_is_ne    = cls.branch & ~funct3[2] & funct3[0];
    alu_next.cmp_is_ge    = cls.branch & funct3[2] & funct3[0];
    // BLT/BLTU, then the SLT family
    alu_next.cmp_is_lt    = (cls.branch & funct3[2] & ~funct3[0]) |
                            (cls.alu & ~funct3[2] & funct3[1]);
    alu_next.bit_is_and   = cls.alu & (funct3 == 3'd7);
    alu_next.bit_is_or    = cls.alu & (funct3 == 3'd6);
    alu_next.bit_is_xor   = cls.alu & (funct3 == 3'd4);
    // Only looked at by the ALU on a right shift
    alu_next.shift_arith  = bit30;
    alu_next.shift_left   = cls.alu & (funct3 == 3'd1);
    alu_next.shift_right  = cls.alu & (funct3 == 3'd5);
  end

endmodule

//--- logic/imm_gen.sv
// Immediate generator
// Sign extends the I, S, B, U and J immediates and picks the one the
// instruction category uses

`timescale 1ns/1ps

module imm_gen
  import rv32i_pkg::*;
(
  input  instr_u          instr_reg,
  input  instr_class_t    cls,
  output logic [XLEN-1:0] imm
);

  logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

  assign imm_i = {{20{instr_reg.i.imm_11_0[11]}}, instr_reg.i.imm_11_0};
  assign imm_s = {{20{instr_reg.s.imm_11_5[6]}}, instr_reg.s.imm_11_5, instr_reg.s.imm_4_0};

  // Branch and jump offsets are in half words, bit 0 always clear
  assign imm_b = {{19{instr_reg.b.imm_12}}, instr_reg.b.imm_12, instr_reg.b.imm_11,
                  instr_reg.b.imm_10_5, instr_reg.b.imm_4_1, 1'b0};
  assign imm_j = {{11{instr_reg.j.imm_20}}, instr_reg.j.imm_20, instr_reg.j.imm_19_12,
                  instr_reg.j.imm_11, instr_reg.j.imm_10_1, 1'b0};
  assign imm_u = {instr_reg.u.imm_31_12, 12'h000};

  // I format by default, the most common one
  always_comb
  begin
    if (cls.upper)
      imm = imm_u;
    else if (cls.branch)
      imm = imm_b;
    else if (cls.jal)
      imm = imm_j;
    else if (cls.store)
      imm = imm_s;
    else
      imm = imm_i;
  end

endmodule

//--- logic/operand_select.sv
// Operand select
// Forwards write back data over stale register reads and forms the
// ALU inputs, the source indexes and the destination index

`timescale 1ns/1ps

module operand_select
  import rv32i_pkg::*;
(
  input  instr_u               instr_reg,
  input  instr_class_t         cls,
  input  logic [XLEN-1:0]      imm,
  input  logic [XLEN-1:0]      pc_in,
  input  logic [XLEN-1:0]      rs1_rtn,
  input  logic [XLEN-1:0]      rs2_rtn,
  input  logic [REG_IDX_W-1:0] fb_rd,
  input  logic [XLEN-1:0]      fb_rd_val,
  output operands_t            ops_next,
  output logic [REG_IDX_W-1:0] rd_next
);

  logic [REG_IDX_W-1:0] rs1_idx, rs2_idx;
  logic [XLEN-1:0]      rs1, rs2;
  logic                 rs2_used;
  logic                 a_is_pc;

  assign rs1_idx = instr_reg.r.rs1;
  assign rs2_idx = instr_reg.r.rs2;

  // ----------------------------------------
  // Write back bypass
  // ----------------------------------------
  // Register being written this cycle wins over the file, x0 never does
  assign rs1 = (|fb_rd && fb_rd == rs1_idx) ? fb_rd_val : rs1_rtn;
  assign rs2 = (|fb_rd && fb_rd == rs2_idx) ? fb_rd_val : rs2_rtn;

  // R form ALU, stores and branches read rs2
  assign rs2_used = (cls.alu & ~cls.alu_imm) | cls.store | cls.branch;

  // AUIPC and JAL add to the PC
  assign a_is_pc = cls.jal | (cls.upper & ~cls.upper_lui);

  always_comb
  begin
    // LUI and system start from zero
    if (cls.upper_lui | cls.system)
      ops_next.a = '0;
    else if (a_is_pc)
      ops_next.a = pc_in;
    else
      ops_next.a = rs1;

    if (rs2_used)
      ops_next.b = rs2;
    else if (cls.system)
      ops_next.b = TRAP_VECTOR;
    else
      ops_next.b = imm;

    // Store and branch offset
    ops_next.offset = imm;

    // U, J and system formats carry no rs1 field
    ops_next.a_rs_idx = (cls.jal | cls.system | cls.upper) ? '0 : rs1_idx;
    ops_next.b_rs_idx = rs2_used ? rs2_idx : '0;
  end

  assign rd_next = cls.no_wb ? '0 : instr_reg.r.rd;

endmodule

//--- logic/decode_stage_reg.sv
// Decode output register
// Holds on stall, flushes on a PC redirect and raises the synchronous
// exception pulse with its PC and cause

`timescale 1ns/1ps

module decode_stage_reg
  import rv32i_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic                 stall,
  input  logic                 update_pc,
  input  logic [XLEN-1:0]      pc_in,
  input  instr_class_t         cls,
  input  op_ctrl_t             op_next,
  input  alu_ctrl_t            alu_next,
  input  operands_t            ops_next,
  input  logic [REG_IDX_W-1:0] rd_next,
  output logic [REG_IDX_W-1:0] rd,
  output logic [XLEN-1:0]      pc,
  output operands_t            ops,
  output op_ctrl_t             op_ctrl,
  output alu_ctrl_t            alu_ctrl,
  output logic                 cancelled,
  output logic                 exception,
  output exc_t                 exc
);

  logic       update_pc_dly;
  logic       exc_int;
  logic [1:0] exc_dly;
  logic       pc_misaligned;
  logic       redirect;

  assign pc_misaligned = |pc_in[1:0];

  // Taken branch means the trapping instruction never executes
  assign exception = exc_int & ~(update_pc | update_pc_dly);

  // Anything read in behind a PC change is dropped
  assign redirect = update_pc | update_pc_dly | exception | |exc_dly;

  // ----------------------------------------
  // Control state
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      update_pc_dly <= 1'b0;
      exc_dly       <= 2'b00;
      exc_int       <= 1'b0;
      cancelled     <= 1'b0;
      rd            <= '0;
      op_ctrl       <= '0;
      alu_ctrl      <= '0;
    end
    else
    begin
      update_pc_dly <= update_pc;
      exc_dly       <= {exception, exc_dly[1]};
      // Pulses by default
      exc_int       <= 1'b0;
      cancelled     <= 1'b0;

      if (redirect)
      begin
        // Flush, stall has no say here
        rd        <= '0;
        op_ctrl   <= '0;
        alu_ctrl  <= '0;
        cancelled <= 1'b1;
      end
      else if (!stall)
      begin
        exc_int  <= cls.illegal | cls.system | pc_misaligned;
        rd       <= rd_next;
        op_ctrl  <= op_next;
        alu_ctrl <= alu_next;
      end
    end
  end

  // ----------------------------------------
  // Data path
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    pc <= pc_in;

    // A bad fetch address belongs to the instruction before it
    exc.pc <= pc_misaligned ? pc : pc_in;

    // Offset bit 0 is instruction bit 20 for the system I format,
    // which splits EBREAK from ECALL
    if (pc_misaligned)
      exc.cause <= CAUSE_IADDR_ALIGN;
    else if (cls.illegal)
      exc.cause <= CAUSE_ILLEGAL;
    else if (cls.system)
      exc.cause <= ops_next.offset[0] ? CAUSE_BREAKPOINT : CAUSE_ECALL;
    else
      exc.cause <= CAUSE_IADDR_ALIGN;

    if (!redirect && !stall)
      ops <= ops_next;
  end

  // A cancelled slot must not write the register file
  a_cancel_no_rd : assert property (
    @(posedge clk) disable iff (!reset_n)
    cancelled |-> rd == '0
  );

  // Redirect masks the exception for its own cycle and the next
  a_exc_masked : assert property (
    @(posedge clk) disable iff (!reset_n)
    update_pc |-> !exception ##1 !exception
  );

endmodule

//--- logic/rv32i_decode.sv
// RV32I decode stage top level
// Phase 2 instruction latch, combinational decode and the registered
// phase 3 outputs to the ALU

`timescale 1ns/1ps

module rv32i_decode
  import rv32i_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic [XLEN-1:0]      instr,
  input  logic [XLEN-1:0]      pc_in,
  input  logic                 update_pc,
  input  logic                 stall,
  input  logic [XLEN-1:0]      rs1_rtn,
  input  logic [XLEN-1:0]      rs2_rtn,
  input  logic [REG_IDX_W-1:0] fb_rd,
  input  logic [XLEN-1:0]      fb_rd_val,
  output logic [REG_IDX_W-1:0] rs1_prefetch,
  output logic [REG_IDX_W-1:0] rs2_prefetch,
  output logic [REG_IDX_W-1:0] rd,
  output logic [XLEN-1:0]      pc,
  output operands_t            ops,
  output op_ctrl_t             op_ctrl,
  output alu_ctrl_t            alu_ctrl,
  output logic                 cancelled,
  output logic                 exception,
  output exc_t                 exc
);

  // Phase 2 decode nets
  instr_u               instr_reg;
  instr_class_t         cls;
  op_ctrl_t             op_next;
  alu_ctrl_t            alu_next;
  operands_t            ops_next;
  logic [XLEN-1:0]      imm;
  logic [REG_IDX_W-1:0] rd_next;

  instr_latch i_instr_latch (
    .clk          (clk),
    .reset_n      (reset_n),
    .instr        (instr),
    .stall        (stall),
    .instr_reg    (instr_reg),
    .rs1_prefetch (rs1_prefetch),
    .rs2_prefetch (rs2_prefetch)
  );

  opcode_classify i_opcode_classify (
    .instr_reg (instr_reg),
    .cls       (cls),
    .op_next   (op_next),
    .alu_next  (alu_next)
  );

  imm_gen i_imm_gen (
    .instr_reg (instr_reg),
    .cls       (cls),
    .imm       (imm)
  );

  operand_select i_operand_select (
    .instr_reg (instr_reg),
    .cls       (cls),
    .imm       (imm),
    .pc_in     (pc_in),
    .rs1_rtn   (rs1_rtn),
    .rs2_rtn   (rs2_rtn),
    .fb_rd     (fb_rd),
    .fb_rd_val (fb_rd_val),
    .ops_next  (ops_next),
    .rd_next   (rd_next)
  );

  decode_stage_reg i_decode_stage_reg (
    .clk       (clk),
    .reset_n   (reset_n),
    .stall     (stall),
    .update_pc (update_pc),
    .pc_in     (pc_in),
    .cls       (cls),
    .op_next   (op_next),
    .alu_next  (alu_next),
    .ops_next  (ops_next),
    .rd_next   (rd_next),
    .rd        (rd),
    .pc        (pc),
    .ops       (ops),
    .op_ctrl   (op_ctrl),
    .alu_ctrl  (alu_ctrl),
    .cancelled (cancelled),
    .exception (exception),
    .exc       (exc)
  );

endmodule

//--- test/decode_vectors.svh
// RV32I decode stage test vectors
// One row per instruction with its drive values and expected outputs

`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

// Where an expected ALU input comes from
localparam int SRC_ZERO = 0;
localparam int SRC_PC   = 1;
localparam int SRC_RS1  = 2;
localparam int SRC_RS2  = 3;
localparam int SRC_FB   = 4;
localparam int SRC_IMM  = 5;
localparam int SRC_TRAP = 6;

typedef struct {
  string       name;
  logic [31:0] instr;
  logic [31:0] pc;
  int          stall_cycles;
  bit          update_pc;
  logic [4:0]  fb_rd;
  logic [31:0] fb_val;
  // Zero when a redirect leaves the operand register untouched
  bit          check_ops;
  logic [4:0]  rd;
  int          a_src;
  int          b_src;
  logic [31:0] offset;
  logic [4:0]  a_idx;
  logic [4:0]  b_idx;
  // {branch, jump, system, load, store, width}
  logic [7:0]  op;
  // {arith, add_nsub, unsigned, lt, ge, eq, ne, and, or, xor, sra, sll, srl}
  logic [12:0] alu;
  bit          cancelled;
  bit          exception;
  logic [3:0]  cause;
  logic [31:0] exc_pc;
} vector_t;

vector_t vectors[$];

task automatic load_vectors();
  // ALU register and immediate forms
  vectors.push_back('{"add", 32'h002081B3, 32'h100, 0, 0, 5'd0, 32'h0, 1, 5'd3, SRC_RS1,
    SRC_RS2, 32'h2, 5'd1, 5'd2, 8'h00, 13'b1100000000000, 0, 0, 4'd0, 32'h0});
  vectors.push_back('{"sub", 32'h407302B3, 32'h104, 0, 0, 5'd0, 32'h0, 1, 5'd5, SRC_RS1,
    SRC_RS2, 32'h407, 5'd6, 5'd7, 8'h00, 13'b1000000000100, 0, 0, 4'd0, 32'h0});
  vectors.push_back('{"sltu_fwd_rs2", 32'h00A4B433, 32'h108, 0, 0, 5'd10, 32'hCAFE0010, 1,
    5'd8, SRC_RS1, SRC_FB, 32'hA, 5'd9, 5'd10, 8'h03, 13'b0111000000000, 0, 0, 4'd0, 32'h0});
  // fb_rd of x0 against rs1 of x0 must not forward
  vectors.push_back('{"xori_fb_x0", 32'hFFF04593, 32'h10C, 0, 0, 5'd0, 32'hDEADBEEF, 1,
    5'd11, SRC_RS1, SRC_IMM, 32'hFFFFFFFF, 5'd0, 5'd0, 8'h04, 13'b0100000001100,
    0, 0, 4'd0, 32'h0});
  vectors.push_back('{"srai", 32'h4056D613, 32'h110, 0, 0, 5'd0, 32'h0, 1, 5'd12, SRC_RS1,
    SRC_IMM, 32'h405, 5'd13, 5'd0, 8'h05, 13'b0110000000101, 0, 0, 4'd0, 32'h0});
  // Upper, jump, branch and memory forms
  vectors.push_back('{"lui", 32'h12345737, 32'h200, 0, 0, 5'd0, 32'h0, 1, 5'd14, SRC_ZERO,
    SRC_IMM, 32'h12345000, 5'd0, 5'd0, 8'h05, 13'b1100000000000, 0, 0, 4'd0, 32'h0});
  vectors.push_back('{"auipc", 32'h80000797, 32'h300, 0, 0, 5'd0, 32'h0, 1, 5'd15, SRC_PC,
    SRC_IMM, 32'h80000000, 5'd0, 5'd0, 8'h00, 13'b1100000000000, 0, 0, 4'd0, 32'h0});
  vectors.push_back('{"jal", 32'h010000EF, 32'h400, 0, 0, 5'd0, 32'h0, 1, 5'd1, SRC_PC,
    SRC_IMM, 32'h10, 5'd0, 5'd0, 8'h40, 13'b0100000000000, 0, 0, 4'd0, 32'h0});
  vectors.push_back('{"bne_fwd_rs1", 32'hFE311CE3, 32'h404, 0, 0, 5'd2, 32'h12345678, 1,
    5'd0, SRC_FB, SRC_RS2, 32'hFFFFFFF8, 5'd2, 5'd3, 8'h81, 13'b0100001000100,
    0, 0, 4'd0, 32'h0});
  vectors.push_back('{"sw", 32'h00532A23, 32'h408, 0, 0, 5'd0, 32'h0, 1, 5'd0, SRC_RS1,
    SRC_RS2, 32'h14, 5'd6, 5'd5, 8'h0A, 13'b0100000000000, 0, 0, 4'd0, 32'h0});
  vectors.push_back('{"lbu", 32'h00344383, 32'h40C, 0, 0, 5'd0, 32'h0, 1, 5'd7, SRC_RS1,
    SRC_IMM, 32'h3, 5'd8, 5'd0, 8'h14, 13'b0100000000000, 0, 0, 4'd0, 32'h0});
  // Exceptions
  vectors.push_back('{"illegal", 32'h00000000, 32'h500, 0, 0, 5'd0, 32'h0, 1, 5'd0, SRC_RS1,
    SRC_IMM, 32'h0, 5'd0, 5'd0, 8'h00, 13'b0100000000000, 0, 1, 4'd2, 32'h500});
  vectors.push_back('{"ecall", 32'h00000073, 32'h600, 0, 0, 5'd0, 32'h0, 1, 5'd0, SRC_ZERO,
    SRC_TRAP, 32'h0, 5'd0, 5'd0, 8'h20, 13'b0100000000000, 0, 1, 4'd11, 32'h600});
  vectors.push_back('{"ebreak", 32'h00100073, 32'h604, 0, 0, 5'd0, 32'h0, 1, 5'd0, SRC_ZERO,
    SRC_TRAP, 32'h1, 5'd0, 5'd0, 8'h20, 13'b0100000000000, 0, 1, 4'd3, 32'h604});
  // Bad fetch address outranks the ECALL and reports the PC of the slot before
  vectors.push_back('{"pc_misaligned", 32'h00000073, 32'h702, 0, 0, 5'd0, 32'h0, 1, 5'd0,
    SRC_ZERO, SRC_TRAP, 32'h0, 5'd0, 5'd0, 8'h20, 13'b0100000000000, 0, 1, 4'd0, IDLE_PC});
  // Redirect and stall
  vectors.push_back('{"update_pc_illegal", 32'hFFFFFFFF, 32'h900, 0, 1, 5'd0, 32'h0, 0, 5'd0,
    SRC_ZERO, SRC_ZERO, 32'h0, 5'd0, 5'd0, 8'h00, 13'b0, 1, 0, 4'd0, 32'h0});
  vectors.push_back('{"add_stall", 32'h002081B3, 32'h180, 3, 0, 5'd0, 32'h0, 1, 5'd3, SRC_RS1,
    SRC_RS2, 32'h2, 5'd1, 5'd2, 8'h00, 13'b1100000000000, 0, 0, 4'd0, 32'h0});
endtask

`endif

//--- test/tb_rv32i_decode.sv
// RV32I decode stage testbench
// Walks the vector table through the DUT and checks every registered output

`timescale 1ns/1ps

module tb_rv32i_decode
  import rv32i_pkg::*;
();

  // Fetch address used between rows, word aligned
  localparam logic [31:0] IDLE_PC  = 32'h0000_0800;
  localparam logic [31:0] NOP_WORD = 32'h0000_0013;

  `include "decode_vectors.svh"

  logic        clk;
  logic        reset_n;
  logic [31:0] instr;
  logic [31:0] pc_in;
  logic        update_pc;
  logic        stall;
  logic [31:0] rs1_rtn;
  logic [31:0] rs2_rtn;
  logic [4:0]  fb_rd;
  logic [31:0] fb_rd_val;
  logic [4:0]  rs1_prefetch;
  logic [4:0]  rs2_prefetch;
  logic [4:0]  rd;
  logic [31:0] pc;
  operands_t   ops;
  op_ctrl_t    op_ctrl;
  alu_ctrl_t   alu_ctrl;
  logic        cancelled;
  logic        exception;
  exc_t        exc;

  int error_count;
  bit vectors_loaded;

  rv32i_decode i_rv32i_decode (
    .clk          (clk),
    .reset_n      (reset_n),
    .instr        (instr),
    .pc_in        (pc_in),
    .update_pc    (update_pc),
    .stall        (stall),
    .rs1_rtn      (rs1_rtn),
    .rs2_rtn      (rs2_rtn),
    .fb_rd        (fb_rd),
    .fb_rd_val    (fb_rd_val),
    .rs1_prefetch (rs1_prefetch),
    .rs2_prefetch (rs2_prefetch),
    .rd           (rd),
    .pc           (pc),
    .ops          (ops),
    .op_ctrl      (op_ctrl),
    .alu_ctrl     (alu_ctrl),
    .cancelled    (cancelled),
    .exception    (exception),
    .exc          (exc)
  );

  always #50 clk = ~clk;

  // ----------------------------------------
  // Checking helpers
  // ----------------------------------------
  task automatic compare(input string test, input string field, input logic [31:0] expected,
                         input logic [31:0] actual);
    assert (actual === expected)
    else
    begin
      error_count++;
      $display("mismatch %s %s: expected %h actual %h", test, field, expected, actual);
    end
  endtask

  // Resolve an operand source to the value the DUT should present
  function automatic logic [31:0] operand_value(input int src, input vector_t v,
                                                input logic [31:0] r1, input logic [31:0] r2);
    case (src)
      SRC_PC:   return v.pc;
      SRC_RS1:  return r1;
      SRC_RS2:  return r2;
      SRC_FB:   return v.fb_val;
      SRC_IMM:  return v.offset;
      SRC_TRAP: return 32'h4;
      default:  return 32'h0;
    endcase
  endfunction

  task automatic check_decode(input vector_t v, input logic [31:0] r1, input logic [31:0] r2);
    compare(v.name, "rd", v.rd, rd);
    compare(v.name, "op_ctrl", v.op, op_ctrl);
    compare(v.name, "alu_ctrl", v.alu, alu_ctrl);
    if (v.check_ops)
    begin
      compare(v.name, "a", operand_value(v.a_src, v, r1, r2), ops.a);
      compare(v.name, "b", operand_value(v.b_src, v, r1, r2), ops.b);
      compare(v.name, "offset", v.offset, ops.offset);
      compare(v.name, "a_rs_idx", v.a_idx, ops.a_rs_idx);
      compare(v.name, "b_rs_idx", v.b_idx, ops.b_rs_idx);
    end
  endtask

  // ----------------------------------------
  // One row, then idle cycles to drain any redirect
  // ----------------------------------------
  task automatic run_vector(input vector_t v);
    logic [31:0] r1;
    logic [31:0] r2;
    r1 = $urandom;
    r2 = $urandom;
    // Edge 0, instruction into the latch
    @(posedge clk);
    instr     <= v.instr;
    pc_in     <= IDLE_PC;
    update_pc <= 1'b0;
    stall     <= 1'b0;
    fb_rd     <= 5'd0;
    // Edge 1, phase 2 data lines up with instr_reg
    @(posedge clk);
    instr     <= (v.stall_cycles > 0) ? v.instr : NOP_WORD;
    pc_in     <= v.pc;
    update_pc <= v.update_pc;
    fb_rd     <= v.fb_rd;
    fb_rd_val <= v.fb_val;
    rs1_rtn   <= r1;
    rs2_rtn   <= r2;
    // Edge 2, outputs registered
    @(posedge clk);
    instr     <= NOP_WORD;
    pc_in     <= IDLE_PC;
    update_pc <= 1'b0;
    fb_rd     <= 5'd0;
    stall     <= (v.stall_cycles > 0);
    @(negedge clk);
    check_decode(v, r1, r2);
    compare(v.name, "pc", v.pc, pc);
    compare(v.name, "cancelled", v.cancelled, cancelled);
    compare(v.name, "exception", v.exception, exception);
    if (v.exception)
    begin
      compare(v.name, "cause", v.cause, exc.cause);
      compare(v.name, "exc_pc", v.exc_pc, exc.pc);
    end
    // Held outputs and prefetch indexes while stalled
    for (int k = 1; k <= v.stall_cycles; k++)
    begin
      @(posedge clk);
      @(negedge clk);
      check_decode(v, r1, r2);
      compare(v.name, "rs1_prefetch", v.instr[19:15], rs1_prefetch);
      compare(v.name, "rs2_prefetch", v.instr[24:20], rs2_prefetch);
    end
    @(posedge clk);
    // Stall drops only after the last held cycle was seen
    stall <= 1'b0;
    // Slot behind a trap or redirect is flushed
    if (v.exception || v.update_pc)
    begin
      @(negedge clk);
      compare(v.name, "flush cancelled", 32'h1, cancelled);
      compare(v.name, "flush rd", 32'h0, rd);
      compare(v.name, "flush op_ctrl", 32'h0, op_ctrl);
      compare(v.name, "flush alu_ctrl", 32'h0, alu_ctrl);
    end
    @(posedge clk);
  endtask

  // ----------------------------------------
  // Watchdog
  // ----------------------------------------
  initial
  begin : watchdog
    int limit;
    wait (vectors_loaded);
    limit = 8 + 4;
    foreach (vectors[i])
      limit += 6 + vectors[i].stall_cycles;
    repeat (limit) @(posedge clk);
    $display("timeout: vector table did not finish within %0d cycles", limit);
    $display("sim failed");
    $finish;
  end

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial
  begin
    error_count = 0;
    void'($urandom(98));
    load_vectors();
    vectors_loaded = 1'b1;
    clk       = 1'b0;
    reset_n   = 1'b0;
    instr     = NOP_WORD;
    pc_in     = IDLE_PC;
    update_pc = 1'b0;
    stall     = 1'b0;
    rs1_rtn   = '0;
    rs2_rtn   = '0;
    fb_rd     = '0;
    fb_rd_val = '0;
    repeat (8) @(posedge clk);
    reset_n <= 1'b1;
    foreach (vectors[i])
      run_vector(vectors[i]);
    $display("checks done, %0d errors", error_count);
    if (error_count == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

//--- tb.f
+incdir+test
logic/rv32i_pkg.sv
logic/instr_latch.sv
logic/opcode_classify.sv
logic/imm_gen.sv
logic/operand_select.sv
logic/decode_stage_reg.sv
logic/rv32i_decode.sv
test/tb_rv32i_decode.sv
